/* hdl/mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Data and address width
`define MIPS_XLEN 32

// General purpose register count
`define MIPS_NREGS 32

// First fetch address
`define MIPS_RESET_PC 32'h0000_0000

`endif

/* hdl/mips_pkg.sv */
`default_nettype none

`include "mips_params.svh"

package mips_pkg;

    // Data, address and instruction word
    typedef logic [`MIPS_XLEN-1:0] word_t;

    typedef logic [$clog2(`MIPS_NREGS)-1:0] reg_addr_t;

    typedef logic [5:0] opcode_t;   // Instruction bits 31:26
    typedef logic [5:0] funct_t;    // R-type bits 5:0

    // ALU class from the main decoder
    // 00 add, 01 subtract, 10 decode funct
    typedef logic [1:0] alu_op_t;

    typedef enum logic [1:0]
    {
        FETCH,
        EXEC,
        MEM
    } seq_state_t;

endpackage

`default_nettype wire

/* hdl/wb_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface wb_if;
    import mips_pkg::*;

    logic  cyc;
    logic  stb;
    logic  we;
    word_t adr;
    word_t dat_w;     // Master to slave
    word_t dat_r;     // Slave to master, valid with ack
    logic  ack;

    modport master
    (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave
    (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

/* hdl/control.sv */
`timescale 1ns/1ps
`default_nettype none

module control (
    input  mips_pkg::opcode_t i_instr_code,
    input  logic              i_issue,
    output logic              o_reg_dst,
    output logic              o_jump,
    output logic              o_beq,
    output logic              o_bne,
    output logic              o_mem_to_reg,
    output mips_pkg::alu_op_t o_alu_op,
    output logic              o_mem_write,
    output logic              o_mem_read,
    output logic              o_alu_src,
    output logic              o_reg_write,
    output logic              o_ext_op
);
    import mips_pkg::*;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    always_comb
    begin
        o_reg_dst    = 1'b0;
        o_jump       = 1'b0;
        o_beq        = 1'b0;
        o_bne        = 1'b0;
        o_mem_to_reg = 1'b0;
        o_alu_op     = 2'b00;
        o_mem_write  = 1'b0;
        o_mem_read   = 1'b0;
        o_alu_src    = 1'b0;
        o_reg_write  = 1'b0;
        o_ext_op     = 1'b0;

        case (i_instr_code)
            OP_RTYPE:
            begin
                o_reg_dst   = 1'b1;
                o_reg_write = 1'b1;
                o_alu_op    = 2'b10;
            end
            OP_ADDI, OP_ADDIU:
            begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_ext_op    = 1'b1;    // addiu sign-extends too
            end
            OP_LW:
            begin
                o_reg_write  = 1'b1;
                o_alu_src    = 1'b1;
                o_ext_op     = 1'b1;
                o_mem_to_reg = 1'b1;
                o_mem_read   = 1'b1;
            end
            OP_SW:
            begin
                o_alu_src   = 1'b1;
                o_ext_op    = 1'b1;
                o_mem_write = 1'b1;
            end
            OP_J:   o_jump = 1'b1;
            OP_BEQ:
            begin
                o_beq    = 1'b1;
                o_alu_op = 2'b01;
            end
            OP_BNE:
            begin
                o_bne    = 1'b1;
                o_alu_op = 2'b01;
            end
            default: ;    // Unknown opcode runs as a no-op
        endcase

        // Nothing may change state outside the execute cycle
        if (!i_issue)
        begin
            o_reg_write = 1'b0;
            o_mem_write = 1'b0;
            o_mem_read  = 1'b0;
            o_jump      = 1'b0;
            o_beq       = 1'b0;
            o_bne       = 1'b0;
        end
    end

    // An issued instruction comes from a completed fetch
    always_comb
    begin
        assert (!i_issue || !$isunknown(i_instr_code))
            else $error("control: opcode has X bits while issuing");
    end

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mips_pkg::alu_op_t i_alu_op,
    input  mips_pkg::funct_t  i_funct,
    input  mips_pkg::word_t   i_a,
    input  mips_pkg::word_t   i_b,
    output mips_pkg::word_t   o_result,
    output logic              o_zero
);
    import mips_pkg::*;

    localparam funct_t F_ADD = 6'h20;
    localparam funct_t F_SUB = 6'h22;
    localparam funct_t F_AND = 6'h24;
    localparam funct_t F_OR  = 6'h25;
    localparam funct_t F_SLT = 6'h2a;

    word_t sum;
    word_t diff;
    logic  less;

    assign sum  = i_a + i_b;
    assign diff = i_a - i_b;
    assign less = $signed(i_a) < $signed(i_b);

    always_comb
    begin
        case (i_alu_op)
            2'b00: o_result = sum;
            2'b01: o_result = diff;    // Branch compare
            2'b10:
            begin
                case (i_funct)
                    F_ADD:   o_result = sum;
                    F_SUB:   o_result = diff;
                    F_AND:   o_result = i_a & i_b;
                    F_OR:    o_result = i_a | i_b;
                    F_SLT:   o_result = word_t'(less);
                    default: o_result = '0;
                endcase
            end
            default: o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module reg_file (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  mips_pkg::reg_addr_t i_rs,
    input  mips_pkg::reg_addr_t i_rt,
    input  mips_pkg::reg_addr_t i_wr_addr,
    input  logic                i_wr_en,
    input  mips_pkg::word_t     i_wr_data,
    output mips_pkg::word_t     o_rs_data,
    output mips_pkg::word_t     o_rt_data
);
    import mips_pkg::*;

    word_t regs [`MIPS_NREGS];

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < `MIPS_NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wr_en && (i_wr_addr != '0))    // r0 stays zero
        begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_rs_data = regs[i_rs];
    assign o_rt_data = regs[i_rt];

endmodule

`default_nettype wire

/* hdl/fetch_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module fetch_sequencer (
    input  logic            i_clk,
    input  logic            i_rst_n,
    wb_if.master            ibus,
    input  logic            i_is_mem_op,
    input  logic            i_mem_done,
    input  logic            i_take_branch,
    input  logic            i_jump,
    input  mips_pkg::word_t i_branch_target,
    input  mips_pkg::word_t i_jump_target,
    output mips_pkg::word_t o_instr,
    output mips_pkg::word_t o_pc_plus4,
    output logic            o_issue,
    output logic            o_mem_start
);
    import mips_pkg::*;

    seq_state_t state;
    word_t      pc;
    word_t      next_pc;
    word_t      instr_q;
    logic       cyc_q;

    assign o_pc_plus4 = pc + 32'd4;
    assign next_pc    = i_jump ? i_jump_target :
                        i_take_branch ? i_branch_target : o_pc_plus4;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            state <= FETCH;
            pc    <= `MIPS_RESET_PC;
            cyc_q <= 1'b0;
        end
        else
        begin
            case (state)
                FETCH:
                begin
                    if (cyc_q && ibus.ack)
                    begin
                        cyc_q <= 1'b0;
                        state <= EXEC;
                    end
                    else
                    begin
                        cyc_q <= 1'b1;    // First request after reset
                    end
                end
                EXEC:
                begin
                    pc <= next_pc;
                    if (i_is_mem_op)
                    begin
                        state <= MEM;
                    end
                    else
                    begin
                        state <= FETCH;
                        cyc_q <= 1'b1;
                    end
                end
                default:
                begin
                    if (i_mem_done)
                    begin
                        state <= FETCH;
                        cyc_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (cyc_q && ibus.ack)
        begin
            instr_q <= ibus.dat_r;
        end
    end

    assign ibus.cyc    = cyc_q;
    assign ibus.stb    = cyc_q;
    assign ibus.we     = 1'b0;    // Fetch is read only
    assign ibus.adr    = pc;
    assign ibus.dat_w  = '0;
    assign o_instr     = instr_q;
    assign o_issue     = (state == EXEC);
    assign o_mem_start = (state == EXEC) && i_is_mem_op;

    // An open fetch waits for ack with a stable address
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (ibus.stb && !ibus.ack) |=> (ibus.stb && ibus.cyc && $stable(ibus.adr)));

endmodule

`default_nettype wire

/* hdl/load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  logic            i_clk,
    input  logic            i_rst_n,
    wb_if.master            dbus,
    input  logic            i_start,
    input  logic            i_write,
    input  mips_pkg::word_t i_addr,
    input  mips_pkg::word_t i_wdata,
    output mips_pkg::word_t o_rdata,
    output logic            o_done
);
    import mips_pkg::*;

    logic  cyc_q;
    logic  we_q;
    word_t adr_q;
    word_t dat_q;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            cyc_q <= 1'b0;
        end
        else if (i_start)
        begin
            cyc_q <= 1'b1;
        end
        else if (cyc_q && dbus.ack)
        begin
            cyc_q <= 1'b0;
        end
    end

    // Request held stable for the whole cycle
    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            we_q  <= i_write;
            adr_q <= i_addr;
            dat_q <= i_wdata;
        end
    end

    assign dbus.cyc   = cyc_q;
    assign dbus.stb   = cyc_q;
    assign dbus.we    = we_q;
    assign dbus.adr   = adr_q;
    assign dbus.dat_w = dat_q;

    assign o_done  = cyc_q && dbus.ack;
    assign o_rdata = dbus.dat_r;    // Written back in the ack cycle

    // The sequencer must wait in MEM until the open cycle is acked
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_start |-> !cyc_q);

endmodule

`default_nettype wire

/* hdl/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  mips_pkg::word_t   i_instr,
    input  mips_pkg::word_t   i_pc_plus4,
    input  logic              i_reg_dst,
    input  logic              i_beq,
    input  logic              i_bne,
    input  logic              i_mem_to_reg,
    input  mips_pkg::alu_op_t i_alu_op,
    input  logic              i_mem_write,
    input  logic              i_mem_read,
    input  logic              i_alu_src,
    input  logic              i_reg_write,
    input  logic              i_ext_op,
    input  logic              i_issue,
    input  mips_pkg::word_t   i_lsu_rdata,
    input  logic              i_lsu_done,
    output logic              o_take_branch,
    output mips_pkg::word_t   o_branch_target,
    output mips_pkg::word_t   o_jump_target,
    output logic              o_is_mem_op,
    output mips_pkg::word_t   o_mem_addr,
    output mips_pkg::word_t   o_mem_wdata
);
    import mips_pkg::*;

    reg_addr_t rs, rt, rd, dest, ld_dest_q, wr_addr;
    word_t     rs_data, rt_data, ext_imm, alu_b, alu_result, wr_data;
    logic      alu_zero, wr_en;

    assign rs = i_instr[25:21];
    assign rt = i_instr[20:16];
    assign rd = i_instr[15:11];

    assign ext_imm = i_ext_op ? {{16{i_instr[15]}}, i_instr[15:0]} : {16'h0, i_instr[15:0]};
    assign alu_b   = i_alu_src ? ext_imm : rt_data;
    assign dest    = i_reg_dst ? rd : rt;

    // Branch offset is always signed
    assign o_branch_target = i_pc_plus4 + {{14{i_instr[15]}}, i_instr[15:0], 2'b00};
    assign o_jump_target   = {i_pc_plus4[31:28], i_instr[25:0], 2'b00};
    assign o_take_branch   = (i_beq && alu_zero) || (i_bne && !alu_zero);
    assign o_is_mem_op     = i_mem_read || i_mem_write;
    assign o_mem_addr      = alu_result;
    assign o_mem_wdata     = rt_data;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            ld_dest_q <= '0;
        else if (i_mem_read)
            ld_dest_q <= rt;    // Load target kept until ack
    end

    // ALU results in EXEC, load data at dbus ack
    assign wr_en   = i_issue ? (i_reg_write && !i_mem_to_reg) : (i_lsu_done && i_mem_to_reg);
    assign wr_addr = i_issue ? dest : ld_dest_q;
    assign wr_data = i_mem_to_reg ? i_lsu_rdata : alu_result;

    reg_file u_reg_file (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rs      (rs),
        .i_rt      (rt),
        .i_wr_addr (wr_addr),
        .i_wr_en   (wr_en),
        .i_wr_data (wr_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    alu u_alu (
        .i_alu_op (i_alu_op),
        .i_funct  (i_instr[5:0]),
        .i_a      (rs_data),
        .i_b      (alu_b),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

endmodule

`default_nettype wire

/* hdl/mips_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu (
    input  logic            i_clk,
    input  logic            i_rst_n,
    output logic            o_ibus_cyc,
    output logic            o_ibus_stb,
    output mips_pkg::word_t o_ibus_adr,
    input  mips_pkg::word_t i_ibus_dat,
    input  logic            i_ibus_ack,
    output logic            o_dbus_cyc,
    output logic            o_dbus_stb,
    output logic            o_dbus_we,
    output mips_pkg::word_t o_dbus_adr,
    output mips_pkg::word_t o_dbus_dat,
    input  mips_pkg::word_t i_dbus_dat,
    input  logic            i_dbus_ack
);
    import mips_pkg::*;

    wb_if ibus ();
    wb_if dbus ();

    logic    reg_dst, jump, beq, bne, mem_to_reg, mem_write, mem_read;
    logic    alu_src, reg_write, ext_op;
    alu_op_t alu_op;
    logic    issue, mem_start, mem_done, take_branch, is_mem_op;
    word_t   instr, pc_plus4, branch_target, jump_target;
    word_t   mem_addr, mem_wdata, lsu_rdata;

    assign o_ibus_cyc = ibus.cyc;
    assign o_ibus_stb = ibus.stb;
    assign o_ibus_adr = ibus.adr;
    assign ibus.dat_r = i_ibus_dat;
    assign ibus.ack   = i_ibus_ack;

    assign o_dbus_cyc = dbus.cyc;
    assign o_dbus_stb = dbus.stb;
    assign o_dbus_we  = dbus.we;
    assign o_dbus_adr = dbus.adr;
    assign o_dbus_dat = dbus.dat_w;
    assign dbus.dat_r = i_dbus_dat;
    assign dbus.ack   = i_dbus_ack;

    control u_control (
        .i_instr_code (instr[31:26]),
        .i_issue      (issue),
        .o_reg_dst    (reg_dst),
        .o_jump       (jump),
        .o_beq        (beq),
        .o_bne        (bne),
        .o_mem_to_reg (mem_to_reg),
        .o_alu_op     (alu_op),
        .o_mem_write  (mem_write),
        .o_mem_read   (mem_read),
        .o_alu_src    (alu_src),
        .o_reg_write  (reg_write),
        .o_ext_op     (ext_op)
    );

    fetch_sequencer u_fetch_sequencer (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .ibus            (ibus.master),
        .i_is_mem_op     (is_mem_op),
        .i_mem_done      (mem_done),
        .i_take_branch   (take_branch),
        .i_jump          (jump),
        .i_branch_target (branch_target),
        .i_jump_target   (jump_target),
        .o_instr         (instr),
        .o_pc_plus4      (pc_plus4),
        .o_issue         (issue),
        .o_mem_start     (mem_start)
    );

    load_store_unit u_load_store_unit (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .dbus    (dbus.master),
        .i_start (mem_start),
        .i_write (mem_write),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (lsu_rdata),
        .o_done  (mem_done)
    );

    datapath u_datapath (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_instr         (instr),
        .i_pc_plus4      (pc_plus4),
        .i_reg_dst       (reg_dst),
        .i_beq           (beq),
        .i_bne           (bne),
        .i_mem_to_reg    (mem_to_reg),
        .i_alu_op        (alu_op),
        .i_mem_write     (mem_write),
        .i_mem_read      (mem_read),
        .i_alu_src       (alu_src),
        .i_reg_write     (reg_write),
        .i_ext_op        (ext_op),
        .i_issue         (issue),
        .i_lsu_rdata     (lsu_rdata),
        .i_lsu_done      (mem_done),
        .o_take_branch   (take_branch),
        .o_branch_target (branch_target),
        .o_jump_target   (jump_target),
        .o_is_mem_op     (is_mem_op),
        .o_mem_addr      (mem_addr),
        .o_mem_wdata     (mem_wdata)
    );

endmodule

`default_nettype wire

/* verification/wb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model #(
    parameter int ADDR_BITS = 10,
    parameter int MAX_DELAY = 5
) (
    input  logic        i_clk,
    input  logic        i_cyc,
    input  logic        i_stb,
    input  logic        i_we,
    input  logic [31:0] i_adr,
    input  logic [31:0] i_dat,
    output logic [31:0] o_dat,
    output logic        o_ack
);

    logic [31:0]          mem [2**ADDR_BITS];    // Filled by the testbench
    logic [ADDR_BITS-1:0] idx;
    int                   wait_cnt;

    assign idx = i_adr[ADDR_BITS+1:2];

    initial
    begin
        o_ack    = 1'b0;
        o_dat    = '0;
        wait_cnt = 0;
    end

    // Outputs change a small delay after the edge
    always @(posedge i_clk)
    begin
        #1;
        if (o_ack)
        begin
            o_ack = 1'b0;    // Single cycle ack
        end
        else if (i_cyc && i_stb)
        begin
            if (wait_cnt > 0)
            begin
                wait_cnt--;
            end
            else
            begin
                if (i_we)
                    mem[idx] = i_dat;
                else
                    o_dat = mem[idx];
                o_ack    = 1'b1;
                wait_cnt = $urandom_range(MAX_DELAY, 0);    // Latency of the next access
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_mips_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module tb_mips_cpu;

    localparam logic [5:0] OP_RTYPE = 6'h00, OP_J = 6'h02, OP_BEQ = 6'h04, OP_BNE = 6'h05;
    localparam logic [5:0] OP_ADDI = 6'h08, OP_ADDIU = 6'h09, OP_LW = 6'h23, OP_SW = 6'h2b;
    localparam logic [5:0] F_ADD = 6'h20, F_SUB = 6'h22, F_AND = 6'h24, F_OR = 6'h25;
    localparam logic [5:0] F_SLT = 6'h2a;
    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT_CYCLES = 20000;

    logic        clk, rst_n;
    logic        ibus_cyc, ibus_stb, ibus_ack, dbus_cyc, dbus_stb, dbus_we, dbus_ack;
    logic [31:0] ibus_adr, ibus_dat, dbus_adr, dbus_dat_w, dbus_dat_r;

    logic [31:0] prog [MEM_WORDS];
    logic [31:0] ref_dmem [MEM_WORDS];
    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    int          prog_len;
    int          stores_seen;
    logic        first_fetch_seen;

    mips_cpu u_dut (
        .i_clk (clk), .i_rst_n (rst_n),
        .o_ibus_cyc (ibus_cyc), .o_ibus_stb (ibus_stb), .o_ibus_adr (ibus_adr),
        .i_ibus_dat (ibus_dat), .i_ibus_ack (ibus_ack),
        .o_dbus_cyc (dbus_cyc), .o_dbus_stb (dbus_stb), .o_dbus_we (dbus_we),
        .o_dbus_adr (dbus_adr), .o_dbus_dat (dbus_dat_w),
        .i_dbus_dat (dbus_dat_r), .i_dbus_ack (dbus_ack)
    );

    wb_mem_model u_imem (
        .i_clk (clk), .i_cyc (ibus_cyc), .i_stb (ibus_stb), .i_we (1'b0),
        .i_adr (ibus_adr), .i_dat (32'h0), .o_dat (ibus_dat), .o_ack (ibus_ack)
    );

    wb_mem_model u_dmem (
        .i_clk (clk), .i_cyc (dbus_cyc), .i_stb (dbus_stb), .i_we (dbus_we),
        .i_adr (dbus_adr), .i_dat (dbus_dat_w), .o_dat (dbus_dat_r), .o_ack (dbus_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] rtype_instr(logic [5:0] funct, int rd, int rs, int rt);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic logic [31:0] itype_instr(logic [5:0] op, int rt, int rs, logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] jump_instr(int word_index);
        return {OP_J, word_index[25:0]};
    endfunction

    task automatic place(logic [31:0] instr);
        prog[prog_len] = instr;
        prog_len++;
    endtask

    task automatic stop_with_failure(string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Executes the program from the ISA rules and records every store
    function automatic void predict_stores();
        logic [31:0] regs [32];
        logic [31:0] pc, instr, simm, addr, a, b, res;
        int          rs, rt, rd;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        pc = `MIPS_RESET_PC;
        for (int step = 0; step < 4000; step++)
        begin
            instr = prog[pc[11:2]];
            rs    = int'(instr[25:21]);
            rt    = int'(instr[20:16]);
            rd    = int'(instr[15:11]);
            simm  = {{16{instr[15]}}, instr[15:0]};
            a     = regs[rs];
            b     = regs[rt];
            addr  = a + simm;
            if (instr[31:26] == OP_J && {pc[31:28], instr[25:0], 2'b00} == pc)
                break;    // Self-jump ends the program
            case (instr[31:26])
                OP_RTYPE:
                begin
                    case (instr[5:0])
                        F_ADD:   res = a + b;
                        F_SUB:   res = a - b;
                        F_AND:   res = a & b;
                        F_OR:    res = a | b;
                        F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: res = '0;
                    endcase
                    regs[rd] = res;
                end
                OP_ADDI, OP_ADDIU: regs[rt] = addr;
                OP_LW:             regs[rt] = ref_dmem[addr[11:2]];
                OP_SW:
                begin
                    exp_adr.push_back(addr);
                    exp_dat.push_back(b);
                    ref_dmem[addr[11:2]] = b;
                end
                default: ;
            endcase
            regs[0] = '0;
            if (instr[31:26] == OP_J)
                pc = {pc[31:28], instr[25:0], 2'b00};
            else if ((instr[31:26] == OP_BEQ && a == b) || (instr[31:26] == OP_BNE && a != b))
                pc = pc + 32'd4 + {simm[29:0], 2'b00};
            else
                pc = pc + 32'd4;
        end
    endfunction

    task automatic build_program();
        logic [15:0] neg_a, neg_b;
        neg_a = 16'h8000 | 16'($urandom);
        neg_b = 16'h8000 | 16'($urandom);
        prog_len = 0;
        place(itype_instr(OP_LW, 1, 0, 16'h0100));
        place(itype_instr(OP_LW, 2, 0, 16'h0104));
        place(itype_instr(OP_ADDI, 3, 0, neg_a));         // Negative operand for slt
        place(rtype_instr(F_ADD, 4, 1, 2));
        place(itype_instr(OP_SW, 4, 0, 16'h0200));
        place(rtype_instr(F_SUB, 4, 1, 2));
        place(itype_instr(OP_SW, 4, 0, 16'h0204));
        place(rtype_instr(F_AND, 4, 1, 2));
        place(itype_instr(OP_SW, 4, 0, 16'h0208));
        place(rtype_instr(F_OR, 4, 1, 2));
        place(itype_instr(OP_SW, 4, 0, 16'h020c));
        place(rtype_instr(F_SLT, 4, 1, 3));
        place(itype_instr(OP_SW, 4, 0, 16'h0210));
        place(rtype_instr(F_SLT, 4, 3, 1));
        place(itype_instr(OP_SW, 4, 0, 16'h0214));
        place(itype_instr(OP_ADDIU, 5, 1, neg_b));
        place(itype_instr(OP_SW, 5, 0, 16'h0218));
        place(itype_instr(OP_ADDI, 6, 1, neg_b));
        place(itype_instr(OP_SW, 6, 0, 16'h021c));
        place(itype_instr(OP_ADDI, 0, 1, 16'h0005));      // r0 must stay zero
        place(itype_instr(OP_SW, 0, 0, 16'h0220));
        place(itype_instr(OP_SW, 1, 0, 16'h0300));
        place(itype_instr(OP_SW, 2, 0, 16'h0304));
        place(itype_instr(OP_LW, 7, 0, 16'h0300));
        place(itype_instr(OP_LW, 8, 0, 16'h0108));
        place(itype_instr(OP_SW, 7, 0, 16'h0224));
        place(itype_instr(OP_SW, 8, 0, 16'h0228));
        place(itype_instr(OP_LW, 9, 0, 16'h0304));
        place(itype_instr(OP_SW, 9, 0, 16'h022c));
        place(itype_instr(OP_BEQ, 1, 1, 16'h0001));       // Taken forward
        place(itype_instr(OP_SW, 0, 0, 16'h03f0));
        place(itype_instr(OP_BNE, 1, 1, 16'h0001));       // Not taken
        place(itype_instr(OP_SW, 1, 0, 16'h0230));
        place(itype_instr(OP_BEQ, 2, 1, 16'h0001));
        place(itype_instr(OP_SW, 2, 0, 16'h0234));
        place(itype_instr(OP_ADDI, 10, 0, 16'h0003));
        place(itype_instr(OP_ADDI, 10, 10, 16'hffff));    // Loop body
        place(itype_instr(OP_SW, 10, 0, 16'h0238));
        place(itype_instr(OP_BNE, 0, 10, 16'hfffd));      // Backward
        place(jump_instr(41));
        place(itype_instr(OP_SW, 0, 0, 16'h03f4));
        place(32'hfc00_0000);                             // Unknown opcode
        place(itype_instr(OP_SW, 3, 0, 16'h023c));
        place(jump_instr(43));
    endtask

    // Store checker, sampled away from the active edge
    always @(negedge clk)
    begin
        if (rst_n && dbus_cyc && dbus_stb && dbus_we && dbus_ack)
        begin
            assert (stores_seen < exp_adr.size())
                else stop_with_failure("unexpected data bus write after the last expected store");
            assert (dbus_adr == exp_adr[stores_seen])
                else stop_with_failure($sformatf("error at %0t: o_dbus_adr expected %h got %h",
                    $time, exp_adr[stores_seen], dbus_adr));
            assert (dbus_dat_w == exp_dat[stores_seen])
                else stop_with_failure($sformatf("error at %0t: o_dbus_dat expected %h got %h",
                    $time, exp_dat[stores_seen], dbus_dat_w));
            stores_seen++;
        end
    end

    // Each master raises and drops cyc and stb together
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            assert (ibus_stb == ibus_cyc)
                else stop_with_failure($sformatf("error at %0t: o_ibus_stb expected %b got %b",
                    $time, ibus_cyc, ibus_stb));
            assert (dbus_stb == dbus_cyc)
                else stop_with_failure($sformatf("error at %0t: o_dbus_stb expected %b got %b",
                    $time, dbus_cyc, dbus_stb));
        end
    end

    // Nothing on the data bus before the first fetch from the reset PC
    always @(negedge clk)
    begin
        if (rst_n && !first_fetch_seen)
        begin
            assert (!dbus_cyc)
                else stop_with_failure("data bus cycle started before the first fetch");
            if (ibus_cyc)
            begin
                assert (ibus_adr == `MIPS_RESET_PC)
                    else stop_with_failure(
                        $sformatf("error at %0t: o_ibus_adr expected %h got %h",
                            $time, `MIPS_RESET_PC, ibus_adr));
                first_fetch_seen = 1'b1;
            end
        end
    end

    initial
    begin
        int cycles;
        void'($urandom(32'hb422_9c28));
        rst_n            = 1'b0;
        stores_seen      = 0;
        first_fetch_seen = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            prog[i]         = (i * 32'h9e37_79b9) ^ 32'h0f0f_1234;    // Never reached
            ref_dmem[i]     = (i * 32'h6d2b_79f5) + 32'h1357_9bdf;
            u_dmem.mem[i]   = ref_dmem[i];
        end
        for (int i = 64; i < 67; i++)
        begin
            ref_dmem[i]   = $urandom;
            u_dmem.mem[i] = ref_dmem[i];
        end
        build_program();
        for (int i = 0; i < MEM_WORDS; i++)
            u_imem.mem[i] = prog[i];
        predict_stores();

        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        cycles = 0;
        while (stores_seen < exp_adr.size())
        begin
            @(posedge clk);
            cycles++;
            assert (cycles <= TIMEOUT_CYCLES)
                else stop_with_failure("timeout waiting for the expected stores");
        end
        // Idle on the final self-jump to catch any late store
        repeat (40) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+hdl
hdl/mips_pkg.sv
hdl/wb_if.sv
hdl/control.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/fetch_sequencer.sv
hdl/load_store_unit.sv
hdl/datapath.sv
hdl/mips_cpu.sv
verification/wb_mem_model.sv
verification/tb_mips_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_mips_cpu -f src.f -o tb_mips_cpu
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_mips_cpu > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation finished without failure"
exit 0
